/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - .
    files:
      - ex_pkg.sv
      - ex_alu.sv
      - ex_mult.sv
      - ex_branch.sv
      - ex_issue_ctrl.sv
      - ex_complete_queue.sv
      - ex_stage.sv
      - target: test
        files:
          - tb_ex_stage.sv

/* ex_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_alu (
	input  logic [`XLEN-1:0]       opa,
	input  logic [`XLEN-1:0]       opb,
	input  ex_pkg::alu_func_e      func,
	output logic [`XLEN-1:0]       result
);

	localparam int SHAMT_BITS = $clog2(`XLEN);

	logic signed [`XLEN-1:0] opa_s;
	logic signed [`XLEN-1:0] opb_s;
	logic [SHAMT_BITS-1:0]   shamt;
	logic                    lt_signed;
	logic                    lt_unsigned;

	assign opa_s = opa;
	assign opb_s = opb;

	// shift amount from the low bits of opb only
	assign shamt = opb[SHAMT_BITS-1:0];

	assign lt_signed   = opa_s < opb_s;
	assign lt_unsigned = opa < opb;

	always_comb begin
		case (func)
			ex_pkg::ALU_ADD:
				result = opa + opb;
			ex_pkg::ALU_SUB:
				result = opa - opb;
			ex_pkg::ALU_AND:
				result = opa & opb;
			ex_pkg::ALU_OR:
				result = opa | opb;
			ex_pkg::ALU_XOR:
				result = opa ^ opb;
			ex_pkg::ALU_SLT:
				result = {{(`XLEN-1){1'b0}}, lt_signed};
			ex_pkg::ALU_SLTU:
				result = {{(`XLEN-1){1'b0}}, lt_unsigned};
			ex_pkg::ALU_SLL:
				result = opa << shamt;
			ex_pkg::ALU_SRL:
				result = opa >> shamt;
			// sign fill from opa
			ex_pkg::ALU_SRA:
				result = opa_s >>> shamt;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* ex_branch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_branch (
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	input  ex_pkg::br_func_e   func,
	input  logic               uncond,
	input  logic [`XLEN-1:0]   rs1,
	input  logic [`XLEN-1:0]   rs2,
	input  logic [`XLEN-1:0]   pc,
	input  logic [`XLEN-1:0]   imm,
	output logic               branch_valid,
	output logic               take_branch,
	output logic [`XLEN-1:0]   branch_target
);

	logic signed [`XLEN-1:0] rs1_s;
	logic signed [`XLEN-1:0] rs2_s;
	logic                    cond;

	assign rs1_s = rs1;
	assign rs2_s = rs2;

	always_comb begin
		case (func)
			ex_pkg::BR_EQ:  cond = rs1 == rs2;
			ex_pkg::BR_NE:  cond = rs1 != rs2;
			ex_pkg::BR_LT:  cond = rs1_s < rs2_s;
			ex_pkg::BR_GE:  cond = rs1_s >= rs2_s;
			ex_pkg::BR_LTU: cond = rs1 < rs2;
			ex_pkg::BR_GEU: cond = rs1 >= rs2;
			default:        cond = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			branch_valid <= 1'b0;
			take_branch  <= 1'b0;
		end else begin
			branch_valid <= start;
			take_branch  <= start & (uncond | cond);
		end
	end

	// target only means something while branch_valid is high
	always_ff @(posedge clock) begin
		branch_target <= pc + imm;
	end

endmodule

`default_nettype wire

/* ex_complete_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_complete_queue (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 wr_a_valid,
	input  logic [`TAG_BITS-1:0] wr_a_tag,
	input  logic [`XLEN-1:0]     wr_a_data,
	input  logic                 wr_b_valid,
	input  logic [`TAG_BITS-1:0] wr_b_tag,
	input  logic [`XLEN-1:0]     wr_b_data,
	output logic                 rd_valid,
	output logic [`TAG_BITS-1:0] rd_tag,
	output logic [`XLEN-1:0]     rd_data
);

	localparam int PTR_BITS = $clog2(`CQ_DEPTH);
	localparam int CNT_BITS = PTR_BITS + 1;

	logic [`TAG_BITS-1:0] tag_mem  [`CQ_DEPTH];
	logic [`XLEN-1:0]     data_mem [`CQ_DEPTH];

	logic [PTR_BITS-1:0]  head;
	logic [PTR_BITS-1:0]  tail;
	logic [CNT_BITS-1:0]  count;
	logic [PTR_BITS-1:0]  wr_b_ptr;
	logic                 pop;

	// B slides into A's slot when A is idle
	assign wr_b_ptr = tail + PTR_BITS'(wr_a_valid);

	// no ready on the read side, the head leaves every cycle
	assign pop = count != '0;

	always_ff @(posedge clock) begin
		if (wr_a_valid) begin
			tag_mem[tail]  <= wr_a_tag;
			data_mem[tail] <= wr_a_data;
		end
		if (wr_b_valid) begin
			tag_mem[wr_b_ptr]  <= wr_b_tag;
			data_mem[wr_b_ptr] <= wr_b_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= head + PTR_BITS'(pop);
			tail  <= tail + PTR_BITS'(wr_a_valid) + PTR_BITS'(wr_b_valid);
			count <= count + CNT_BITS'(wr_a_valid) + CNT_BITS'(wr_b_valid)
				- CNT_BITS'(pop);
		end
	end

	assign rd_valid = pop;
	assign rd_tag   = tag_mem[head];
	assign rd_data  = data_mem[head];

	// sizing against multiplier depth keeps this from filling up
	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		count <= CNT_BITS'(`CQ_DEPTH));

endmodule

`default_nettype wire

/* ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath width
`define XLEN 32

// physical register tag width, tag zero means no destination
`define TAG_BITS 6

// multiplier pipeline, stages times bits per stage covers XLEN
`define MULT_STAGES 4
`define MULT_WIDTH 8

// completion queue entries, power of two
`define CQ_DEPTH 8

`endif

/* ex_issue_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_issue_ctrl (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 issue_valid,
	input  ex_pkg::unit_e        issue_unit,
	input  ex_pkg::opa_sel_e     issue_opa_sel,
	input  ex_pkg::opb_sel_e     issue_opb_sel,
	input  logic [`XLEN-1:0]     issue_pc,
	input  logic [`XLEN-1:0]     issue_rs1,
	input  logic [`XLEN-1:0]     issue_rs2,
	input  logic [`XLEN-1:0]     issue_imm,
	input  logic [`TAG_BITS-1:0] issue_tag,
	output logic [`XLEN-1:0]     alu_opa,
	output logic [`XLEN-1:0]     alu_opb,
	input  logic [`XLEN-1:0]     alu_result,
	output logic                 mult_start,
	output logic                 branch_start,
	input  logic                 mult_done,
	input  logic [`TAG_BITS-1:0] mult_tag,
	input  logic [`XLEN-1:0]     mult_product,
	output logic                 wr_a_valid,
	output logic [`TAG_BITS-1:0] wr_a_tag,
	output logic [`XLEN-1:0]     wr_a_data,
	output logic                 wr_b_valid,
	output logic [`TAG_BITS-1:0] wr_b_tag,
	output logic [`XLEN-1:0]     wr_b_data
);

	logic alu_start;

	//////////////////////////////
	// steering
	//////////////////////////////

	assign alu_start    = issue_valid && (issue_unit == ex_pkg::UNIT_ALU);
	assign mult_start   = issue_valid && (issue_unit == ex_pkg::UNIT_MULT);
	assign branch_start = issue_valid && (issue_unit == ex_pkg::UNIT_BRANCH);

	always_comb begin
		case (issue_opa_sel)
			ex_pkg::OPA_RS1: alu_opa = issue_rs1;
			ex_pkg::OPA_PC:  alu_opa = issue_pc;
			default:         alu_opa = '0;
		endcase
	end

	assign alu_opb = (issue_opb_sel == ex_pkg::OPB_IMM) ? issue_imm : issue_rs2;

	//////////////////////////////
	// completion merge
	//////////////////////////////

	// finishing multiply gets the earlier queue slot
	assign wr_a_valid = mult_done && (mult_tag != '0);
	assign wr_a_tag   = mult_tag;
	assign wr_a_data  = mult_product;

	assign wr_b_valid = alu_start && (issue_tag != '0);
	assign wr_b_tag   = issue_tag;
	assign wr_b_data  = alu_result;

	a_unit_legal: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> issue_unit inside {ex_pkg::UNIT_ALU, ex_pkg::UNIT_MULT,
			ex_pkg::UNIT_BRANCH});

endmodule

`default_nettype wire

/* ex_mult.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_mult (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  logic [`XLEN-1:0]     mcand,
	input  logic [`XLEN-1:0]     mplier,
	input  logic [`TAG_BITS-1:0] tag_in,
	output logic [`XLEN-1:0]     product,
	output logic [`TAG_BITS-1:0] tag_out,
	output logic                 done
);

	// stage registers, operands are not needed after the last stage
	logic [`XLEN-1:0]     prod_q   [`MULT_STAGES];
	logic [`XLEN-1:0]     mcand_q  [`MULT_STAGES-1];
	logic [`XLEN-1:0]     mplier_q [`MULT_STAGES-1];
	logic [`TAG_BITS-1:0] tag_q    [`MULT_STAGES];
	logic                 done_q   [`MULT_STAGES];

	for (genvar i = 0; i < `MULT_STAGES; i++) begin : g_stage
		logic [`XLEN-1:0]     prod_in;
		logic [`XLEN-1:0]     mcand_in;
		logic [`XLEN-1:0]     mplier_in;
		logic [`TAG_BITS-1:0] tag_s;
		logic                 start_s;
		logic [`XLEN-1:0]     partial;

		if (i == 0) begin : g_first
			assign prod_in   = '0;
			assign mcand_in  = mcand;
			assign mplier_in = mplier;
			assign tag_s     = tag_in;
			assign start_s   = start;
		end else begin : g_next
			assign prod_in   = prod_q[i-1];
			assign mcand_in  = mcand_q[i-1];
			assign mplier_in = mplier_q[i-1];
			assign tag_s     = tag_q[i-1];
			assign start_s   = done_q[i-1];
		end

		// one multiplier digit times the shifted multiplicand
		assign partial = mcand_in * mplier_in[`MULT_WIDTH-1:0];

		always_ff @(posedge clock) begin
			prod_q[i] <= prod_in + partial;
		end

		if (i < `MULT_STAGES-1) begin : g_shift
			always_ff @(posedge clock) begin
				mcand_q[i]  <= mcand_in << `MULT_WIDTH;
				mplier_q[i] <= mplier_in >> `MULT_WIDTH;
			end
		end

		always_ff @(posedge clock) begin
			if (reset) begin
				done_q[i] <= 1'b0;
				tag_q[i]  <= '0;
			end else begin
				done_q[i] <= start_s;
				tag_q[i]  <= tag_s;
			end
		end
	end

	assign product = prod_q[`MULT_STAGES-1];
	assign tag_out = tag_q[`MULT_STAGES-1];
	assign done    = done_q[`MULT_STAGES-1];

	a_done_after_start: assert property (@(posedge clock) disable iff (reset)
		start |-> ##(`MULT_STAGES) done);
	a_done_has_start: assert property (@(posedge clock) disable iff (reset)
		done |-> $past(start, `MULT_STAGES));

endmodule

`default_nettype wire

/* ex_pkg.sv */
`default_nettype none

package ex_pkg;

	//////////////////////////////
	// issue steering
	//////////////////////////////

	typedef enum logic [1:0] {
		UNIT_ALU    = 2'd0,
		UNIT_MULT   = 2'd1,
		UNIT_BRANCH = 2'd2
	} unit_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_SRL  = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRA  = 4'd9
	} alu_func_e;

	// funct3 encodings of the conditional branches
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} br_func_e;

	//////////////////////////////
	// operand selects
	//////////////////////////////

	typedef enum logic [1:0] {
		OPA_RS1  = 2'd0,
		OPA_PC   = 2'd1,
		OPA_ZERO = 2'd2
	} opa_sel_e;

	typedef enum logic {
		OPB_RS2 = 1'b0,
		OPB_IMM = 1'b1
	} opb_sel_e;

endpackage

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 issue_valid,
	input  ex_pkg::unit_e        issue_unit,
	input  ex_pkg::alu_func_e    issue_alu_func,
	input  ex_pkg::br_func_e     issue_br_func,
	input  ex_pkg::opa_sel_e     issue_opa_sel,
	input  ex_pkg::opb_sel_e     issue_opb_sel,
	input  logic                 issue_uncond,
	input  logic [`XLEN-1:0]     issue_pc,
	input  logic [`XLEN-1:0]     issue_rs1,
	input  logic [`XLEN-1:0]     issue_rs2,
	input  logic [`XLEN-1:0]     issue_imm,
	input  logic [`TAG_BITS-1:0] issue_tag,
	output logic                 complete_valid,
	output logic [`TAG_BITS-1:0] complete_tag,
	output logic [`XLEN-1:0]     complete_result,
	output logic                 branch_valid,
	output logic                 take_branch,
	output logic [`XLEN-1:0]     branch_target
);

	logic [`XLEN-1:0]     alu_opa;
	logic [`XLEN-1:0]     alu_opb;
	logic [`XLEN-1:0]     alu_result;
	logic                 mult_start;
	logic                 branch_start;
	logic                 mult_done;
	logic [`TAG_BITS-1:0] mult_tag;
	logic [`XLEN-1:0]     mult_product;
	logic                 wr_a_valid;
	logic [`TAG_BITS-1:0] wr_a_tag;
	logic [`XLEN-1:0]     wr_a_data;
	logic                 wr_b_valid;
	logic [`TAG_BITS-1:0] wr_b_tag;
	logic [`XLEN-1:0]     wr_b_data;

	ex_issue_ctrl issue_ctrl_i (
		.clock, .reset, .issue_valid, .issue_unit, .issue_opa_sel, .issue_opb_sel,
		.issue_pc, .issue_rs1, .issue_rs2, .issue_imm, .issue_tag,
		.alu_opa, .alu_opb, .alu_result, .mult_start, .branch_start,
		.mult_done, .mult_tag, .mult_product,
		.wr_a_valid, .wr_a_tag, .wr_a_data, .wr_b_valid, .wr_b_tag, .wr_b_data
	);

	ex_alu alu_i (.opa(alu_opa), .opb(alu_opb), .func(issue_alu_func), .result(alu_result));

	// operands come straight from issue, only the strobe is steered
	ex_mult mult_i (
		.clock, .reset, .start(mult_start), .mcand(issue_rs1), .mplier(issue_rs2),
		.tag_in(issue_tag), .product(mult_product), .tag_out(mult_tag), .done(mult_done)
	);

	ex_branch branch_i (
		.clock, .reset, .start(branch_start), .func(issue_br_func), .uncond(issue_uncond),
		.rs1(issue_rs1), .rs2(issue_rs2), .pc(issue_pc), .imm(issue_imm),
		.branch_valid, .take_branch, .branch_target
	);

	ex_complete_queue complete_queue_i (
		.clock, .reset, .wr_a_valid, .wr_a_tag, .wr_a_data, .wr_b_valid, .wr_b_tag, .wr_b_data,
		.rd_valid(complete_valid), .rd_tag(complete_tag), .rd_data(complete_result)
	);

endmodule

`default_nettype wire

/* tb_ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module tb_ex_stage;

	logic                 clock;
	logic                 reset;
	logic                 issue_valid;
	ex_pkg::unit_e        issue_unit;
	ex_pkg::alu_func_e    issue_alu_func;
	ex_pkg::br_func_e     issue_br_func;
	ex_pkg::opa_sel_e     issue_opa_sel;
	ex_pkg::opb_sel_e     issue_opb_sel;
	logic                 issue_uncond;
	logic [`XLEN-1:0]     issue_pc;
	logic [`XLEN-1:0]     issue_rs1;
	logic [`XLEN-1:0]     issue_rs2;
	logic [`XLEN-1:0]     issue_imm;
	logic [`TAG_BITS-1:0] issue_tag;
	logic                 complete_valid;
	logic [`TAG_BITS-1:0] complete_tag;
	logic [`XLEN-1:0]     complete_result;
	logic                 branch_valid;
	logic                 take_branch;
	logic [`XLEN-1:0]     branch_target;

	// expected results by tag and expected queue order
	logic [`XLEN-1:0]     exp_result [2**`TAG_BITS];
	logic [`TAG_BITS-1:0] exp_q [$];
	logic [`TAG_BITS-1:0] mult_pipe [`MULT_STAGES];
	logic                 exp_cq_valid;
	logic [`TAG_BITS-1:0] exp_cq_tag;
	logic                 exp_br_valid;
	logic                 exp_br_take;
	logic [`XLEN-1:0]     exp_br_target;
	logic                 any_issued;
	logic [`TAG_BITS-1:0] next_tag;
	int                   errors;
	int                   timeouts;
	int                   issued;
	int                   completed;

	ex_stage dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic report(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("CHECK FAILED time=%0t signal=%s expected=0x%08h actual=0x%08h",
			$time, name, expected, actual);
	endtask

	function automatic logic [`XLEN-1:0] alu_expect(ex_pkg::alu_func_e f,
		logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
		case (f)
			ex_pkg::ALU_ADD:  return a + b;
			ex_pkg::ALU_SUB:  return a - b;
			ex_pkg::ALU_AND:  return a & b;
			ex_pkg::ALU_OR:   return a | b;
			ex_pkg::ALU_XOR:  return a ^ b;
			ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
			ex_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
			ex_pkg::ALU_SLL:  return a << b[4:0];
			ex_pkg::ALU_SRL:  return a >> b[4:0];
			ex_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
			default:          return '0;
		endcase
	endfunction

	function automatic logic branch_expect(ex_pkg::br_func_e f, logic uncond,
		logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
		case (f)
			ex_pkg::BR_EQ:  return uncond || (a == b);
			ex_pkg::BR_NE:  return uncond || (a != b);
			ex_pkg::BR_LT:  return uncond || ($signed(a) < $signed(b));
			ex_pkg::BR_GE:  return uncond || ($signed(a) >= $signed(b));
			ex_pkg::BR_LTU: return uncond || (a < b);
			ex_pkg::BR_GEU: return uncond || (a >= b);
			default:        return uncond;
		endcase
	endfunction

	// mostly random with small signed values and the extremes mixed in
	function automatic logic [`XLEN-1:0] rand_operand();
		case ($urandom_range(0, 3))
			0:       return $urandom_range(0, 15) - 8;
			1:       return ($urandom_range(0, 1) == 1) ? 32'h8000_0000 : 32'h7fff_ffff;
			default: return $urandom;
		endcase
	endfunction

	function automatic logic still_busy();
		logic busy;
		busy = (exp_q.size() != 0) || complete_valid;
		for (int i = 0; i < `MULT_STAGES; i++) begin
			busy = busy || (mult_pipe[i] != '0);
		end
		return busy;
	endfunction

	task automatic issue_op(input ex_pkg::unit_e unit, input int func_code,
		input logic [1:0] opa_code, input logic opb_code, input logic uncond);
		logic [`XLEN-1:0] opa_val;
		logic [`XLEN-1:0] opb_val;
		@(posedge clock);
		#2;
		issue_valid    = 1'b1;
		issue_unit     = unit;
		issue_alu_func = ex_pkg::alu_func_e'(func_code);
		issue_br_func  = ex_pkg::br_func_e'(func_code);
		issue_opa_sel  = ex_pkg::opa_sel_e'(opa_code);
		issue_opb_sel  = ex_pkg::opb_sel_e'(opb_code);
		issue_uncond   = uncond;
		issue_pc       = $urandom & 32'hffff_fffc;
		issue_rs1      = rand_operand();
		issue_rs2      = ($urandom_range(0, 3) == 0) ? issue_rs1 : rand_operand();
		issue_imm      = rand_operand();
		// occasional tag zero that must never reach completion
		if ($urandom_range(0, 5) == 0) begin
			issue_tag = '0;
		end else begin
			issue_tag = next_tag;
			next_tag  = (next_tag == '1) ? 1 : next_tag + 1;
		end
		case (opa_code)
			2'd0:    opa_val = issue_rs1;
			2'd1:    opa_val = issue_pc;
			default: opa_val = '0;
		endcase
		opb_val = opb_code ? issue_imm : issue_rs2;
		if (unit == ex_pkg::UNIT_ALU)
			exp_result[issue_tag] = alu_expect(issue_alu_func, opa_val, opb_val);
		else if (unit == ex_pkg::UNIT_MULT)
			exp_result[issue_tag] = issue_rs1 * issue_rs2;
		any_issued = 1'b1;
		issued++;
	endtask

	task automatic issue_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			#2;
			issue_valid = 1'b0;
		end
	endtask

	task automatic wait_drain(input string phase);
		int waited;
		waited = 0;
		issue_idle(1);
		while (still_busy() && waited < 100) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (still_busy()) begin
			timeouts++;
			$display("timeout: completions of the %s phase did not drain in 100 cycles",
				phase);
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	always @(posedge clock) begin
		if (reset) begin
			exp_q.delete();
			for (int i = 0; i < `MULT_STAGES; i++) begin
				mult_pipe[i] = '0;
			end
			exp_cq_valid = 1'b0;
			exp_cq_tag   = '0;
			exp_br_valid = 1'b0;
			exp_br_take  = 1'b0;
		end else begin
			if (exp_q.size() != 0) begin
				void'(exp_q.pop_front());
				completed++;
			end
			// finishing multiply is queued ahead of a same-cycle ALU result
			if (mult_pipe[`MULT_STAGES-1] != '0)
				exp_q.push_back(mult_pipe[`MULT_STAGES-1]);
			if (issue_valid && issue_unit == ex_pkg::UNIT_ALU && issue_tag != '0)
				exp_q.push_back(issue_tag);
			for (int i = `MULT_STAGES-1; i > 0; i--) begin
				mult_pipe[i] = mult_pipe[i-1];
			end
			mult_pipe[0] = (issue_valid && issue_unit == ex_pkg::UNIT_MULT) ? issue_tag : '0;
			exp_cq_valid  = exp_q.size() != 0;
			exp_cq_tag    = exp_cq_valid ? exp_q[0] : '0;
			exp_br_valid  = issue_valid && issue_unit == ex_pkg::UNIT_BRANCH;
			exp_br_take   = exp_br_valid &&
				branch_expect(issue_br_func, issue_uncond, issue_rs1, issue_rs2);
			exp_br_target = issue_pc + issue_imm;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_idle_complete: assert property (@(posedge clock) disable iff (reset)
		!any_issued |-> !complete_valid)
		else report("complete_valid", '0, $sampled(complete_valid));
	a_idle_branch: assert property (@(posedge clock) disable iff (reset)
		!any_issued |-> !branch_valid)
		else report("branch_valid", '0, $sampled(branch_valid));
	a_idle_take: assert property (@(posedge clock) disable iff (reset)
		!any_issued |-> !take_branch)
		else report("take_branch", '0, $sampled(take_branch));
	a_complete_valid: assert property (@(posedge clock) disable iff (reset)
		complete_valid == exp_cq_valid)
		else report("complete_valid", $sampled(exp_cq_valid), $sampled(complete_valid));
	a_complete_tag: assert property (@(posedge clock) disable iff (reset)
		complete_valid |-> complete_tag == exp_cq_tag)
		else report("complete_tag", $sampled(exp_cq_tag), $sampled(complete_tag));
	a_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
		complete_valid |-> complete_tag != '0)
		else report("complete_tag", $sampled(exp_cq_tag), $sampled(complete_tag));
	a_complete_result: assert property (@(posedge clock) disable iff (reset)
		complete_valid |-> complete_result == exp_result[exp_cq_tag])
		else report("complete_result", exp_result[$sampled(exp_cq_tag)],
			$sampled(complete_result));
	a_branch_valid: assert property (@(posedge clock) disable iff (reset)
		branch_valid == exp_br_valid)
		else report("branch_valid", $sampled(exp_br_valid), $sampled(branch_valid));
	a_take_branch: assert property (@(posedge clock) disable iff (reset)
		take_branch == exp_br_take)
		else report("take_branch", $sampled(exp_br_take), $sampled(take_branch));
	a_branch_target: assert property (@(posedge clock) disable iff (reset)
		branch_valid |-> branch_target == exp_br_target)
		else report("branch_target", $sampled(exp_br_target), $sampled(branch_target));

	//////////////////////////////
	// stimulus
	//////////////////////////

	initial begin
		void'($urandom(32'he4be_a2d4));
		errors         = 0;
		timeouts       = 0;
		issued         = 0;
		completed      = 0;
		any_issued     = 1'b0;
		next_tag       = 1;
		issue_valid    = 1'b0;
		issue_unit     = ex_pkg::UNIT_ALU;
		issue_alu_func = ex_pkg::ALU_ADD;
		issue_br_func  = ex_pkg::BR_EQ;
		issue_opa_sel  = ex_pkg::OPA_RS1;
		issue_opb_sel  = ex_pkg::OPB_RS2;
		issue_uncond   = 1'b0;
		issue_pc       = '0;
		issue_rs1      = '0;
		issue_rs2      = '0;
		issue_imm      = '0;
		issue_tag      = '0;
		reset          = 1'b1;
		repeat (2) @(posedge clock);
		#2 reset = 1'b0;
		issue_idle(4);

		// every ALU function against every operand select back to back
		for (int f = 0; f < 10; f++) begin
			for (int a = 0; a < 3; a++) begin
				for (int b = 0; b < 2; b++) begin
					issue_op(ex_pkg::UNIT_ALU, f, a, b, 1'b0);
				end
			end
		end
		wait_drain("alu");

		// multiplies interleaved with ALU work
		repeat (80) begin
			issue_op(($urandom_range(0, 1) == 1) ? ex_pkg::UNIT_MULT : ex_pkg::UNIT_ALU,
				$urandom_range(0, 9), $urandom_range(0, 2), $urandom_range(0, 1), 1'b0);
		end
		wait_drain("mult");

		// funct3 codes 2 and 3 are not branches
		for (int f = 0; f < 8; f++) begin
			if (f == 2 || f == 3)
				continue;
			for (int u = 0; u < 2; u++) begin
				repeat (6) issue_op(ex_pkg::UNIT_BRANCH, f, 0, 0, u[0]);
			end
		end
		wait_drain("branch");
		issue_idle(2);

		$display("errors=%0d timeouts=%0d issued=%0d completed=%0d",
			errors, timeouts, issued, completed);
		if (errors == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_branch.sv
ex_issue_ctrl.sv
ex_complete_queue.sv
ex_stage.sv
tb_ex_stage.sv
